// File: filelist.f
+incdir+bench
design/decode_pkg.sv
design/instr_field_decoder.sv
design/imm_generator.sv
design/register_file.sv
design/decode_stage.sv
bench/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_decode_stage \
    -o sim_decode_stage \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_decode_stage > sim.log 2>&1
cat sim.log

grep -qx "Everything OK" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// File: bench/tb_vectors.svh
// decode table for tb_decode_stage; included inside the module, needs vec_t and decode_pkg in scope
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    // columns: wb_en, wb_rd, data slot, instr, pc,
    //          fmt, rd, rs1, rs2, funct3, imm, illegal
    localparam int NUM_VECS = 26;

    function automatic vec_t vector_row(input int idx);
        vec_t row;
        row = '0;
        case (idx)
            // fill x1..x3 through writeback, x0 write dropped
            0:  row = '{1'b1, 5'd1, 3'd0, 32'h00000013, 64'h1000,
                        FMT_I, 5'd0, 5'd0, 5'd0, 3'd0, 64'h0, 1'b0};
            1:  row = '{1'b1, 5'd2, 3'd1, 32'h00000013, 64'h1004,
                        FMT_I, 5'd0, 5'd0, 5'd0, 3'd0, 64'h0, 1'b0};
            2:  row = '{1'b1, 5'd3, 3'd2, 32'h00000013, 64'h1008,
                        FMT_I, 5'd0, 5'd0, 5'd0, 3'd0, 64'h0, 1'b0};
            3:  row = '{1'b1, 5'd0, 3'd3, 32'h00000013, 64'h100C,
                        FMT_I, 5'd0, 5'd0, 5'd0, 3'd0, 64'h0, 1'b0};
            // add x5,x1,x2 and mulw x6,x3,x0
            4:  row = '{1'b0, 5'd0, 3'd0, 32'h002082B3, 64'h1010,
                        FMT_R, 5'd5, 5'd1, 5'd2, 3'd0, 64'h0, 1'b0};
            5:  row = '{1'b0, 5'd0, 3'd0, 32'h0201833B, 64'h1014,
                        FMT_R, 5'd6, 5'd3, 5'd0, 3'd0, 64'h0, 1'b0};
            // x1 rewritten while read, new value one row later
            6:  row = '{1'b1, 5'd1, 3'd4, 32'h001083B3, 64'h1018,
                        FMT_R, 5'd7, 5'd1, 5'd1, 3'd0, 64'h0, 1'b0};
            7:  row = '{1'b0, 5'd0, 3'd0, 32'h00208433, 64'h101C,
                        FMT_R, 5'd8, 5'd1, 5'd2, 3'd0, 64'h0, 1'b0};
            // addi -5, ld 0x7f0
            8:  row = '{1'b0, 5'd0, 3'd0, 32'hFFB10493, 64'h1020,
                        FMT_I, 5'd9, 5'd2, 5'd0, 3'd0, 64'hFFFFFFFFFFFFFFFB, 1'b0};
            9:  row = '{1'b0, 5'd0, 3'd0, 32'h7F01B503, 64'h1024,
                        FMT_I, 5'd10, 5'd3, 5'd0, 3'd3, 64'h7F0, 1'b0};
            // sd -16, sw 0x124
            10: row = '{1'b0, 5'd0, 3'd0, 32'hFE20B823, 64'h1028,
                        FMT_S, 5'd0, 5'd1, 5'd2, 3'd3, 64'hFFFFFFFFFFFFFFF0, 1'b0};
            11: row = '{1'b0, 5'd0, 3'd0, 32'h12312223, 64'h102C,
                        FMT_S, 5'd0, 5'd2, 5'd3, 3'd2, 64'h124, 1'b0};
            // beq -8, bne +0x8a4 with bit 11 set
            12: row = '{1'b0, 5'd0, 3'd0, 32'hFE208CE3, 64'h1030,
                        FMT_B, 5'd0, 5'd1, 5'd2, 3'd0, 64'hFFFFFFFFFFFFFFF8, 1'b0};
            13: row = '{1'b0, 5'd0, 3'd0, 32'h0A0192E3, 64'h1034,
                        FMT_B, 5'd0, 5'd3, 5'd0, 3'd1, 64'h8A4, 1'b0};
            // lui negative, auipc positive
            14: row = '{1'b0, 5'd0, 3'd0, 32'h8ABCD5B7, 64'h1038,
                        FMT_U, 5'd11, 5'd0, 5'd0, 3'd5, 64'hFFFFFFFF8ABCD000, 1'b0};
            15: row = '{1'b0, 5'd0, 3'd0, 32'h12345617, 64'h103C,
                        FMT_U, 5'd12, 5'd0, 5'd0, 3'd5, 64'h12345000, 1'b0};
            // jal -20, jal +0x3adb6
            16: row = '{1'b0, 5'd0, 3'd0, 32'hFEDFF6EF, 64'h1040,
                        FMT_J, 5'd13, 5'd0, 5'd0, 3'd7, 64'hFFFFFFFFFFFFFFEC, 1'b0};
            17: row = '{1'b0, 5'd0, 3'd0, 32'h5B73A76F, 64'h1044,
                        FMT_J, 5'd14, 5'd0, 5'd0, 3'd2, 64'h3ADB6, 1'b0};
            // fence with junk rd/rs1, csrrw, jalr, addiw
            18: row = '{1'b0, 5'd0, 3'd0, 32'h0FF1828F, 64'h1048,
                        FMT_I, 5'd0, 5'd0, 5'd0, 3'd0, 64'hFF, 1'b0};
            19: row = '{1'b0, 5'd0, 3'd0, 32'h300117F3, 64'h104C,
                        FMT_I, 5'd15, 5'd2, 5'd0, 3'd1, 64'h300, 1'b0};
            20: row = '{1'b0, 5'd0, 3'd0, 32'hFFC180E7, 64'h1050,
                        FMT_I, 5'd1, 5'd3, 5'd0, 3'd0, 64'hFFFFFFFFFFFFFFFC, 1'b0};
            21: row = '{1'b0, 5'd0, 3'd0, 32'h7FF0881B, 64'h1054,
                        FMT_I, 5'd16, 5'd1, 5'd0, 3'd0, 64'h7FF, 1'b0};
            // opcode 0x7f and all-zero word, then legal again
            22: row = '{1'b1, 5'd2, 3'd5, 32'h0020C3FF, 64'h1058,
                        FMT_R, 5'd7, 5'd1, 5'd2, 3'd4, 64'h0, 1'b1};
            23: row = '{1'b0, 5'd0, 3'd0, 32'h00000000, 64'h105C,
                        FMT_R, 5'd0, 5'd0, 5'd0, 3'd0, 64'h0, 1'b1};
            24: row = '{1'b0, 5'd0, 3'd0, 32'h002082B3, 64'h1060,
                        FMT_R, 5'd5, 5'd1, 5'd2, 3'd0, 64'h0, 1'b0};
            25: row = '{1'b0, 5'd0, 3'd0, 32'h0021E8B3, 64'h1064,
                        FMT_R, 5'd17, 5'd3, 5'd2, 3'd6, 64'h0, 1'b0};
            default: row = '0;
        endcase
        return row;
    endfunction

`endif

// File: bench/tb_decode_stage.sv
// table-driven testbench; assumes 1 cycle latency and that a same-edge write is not seen by the read
`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    // one table row: writeback, instruction, expected decode
    typedef struct packed {
        logic                  wb_en;
        logic [REG_ADDR_W-1:0] wb_rd;
        logic [2:0]            slot;
        logic [INSTR_W-1:0]    instr;
        logic [XLEN-1:0]       pc;
        fmt_e                  fmt;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       imm;
        logic                  illegal;
    } vec_t;

    localparam int RESET_CYCLES  = 10;
    localparam int RESET_TIMEOUT = 50;
    // addi x0, x0, 0
    localparam logic [INSTR_W-1:0] NOP = 32'h00000013;

    logic            clk;
    logic            reset;
    logic [INSTR_W-1:0] instr;
    logic [XLEN-1:0] pc;
    wb_t             wb;
    decoded_t        dec;

    // random register data, picked by slot
    logic [XLEN-1:0] data_pool [8];
    // expected architectural registers
    logic [XLEN-1:0] reg_model [NUM_REGS];

    int          reset_count;
    int          error_count;
    int          check_count;
    int          current_row;
    int unsigned seed_sink;
    logic        released;

    `include "tb_vectors.svh"

    decode_stage #(
        .DATA_W (XLEN),
        .ADDR_W (REG_ADDR_W)
    ) u_dut (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .pc    (pc),
        .wb    (wb),
        .dec   (dec)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // reset drops after the 10th rising edge
    always @(posedge clk) begin
        if (reset_count < RESET_CYCLES - 1) begin
            reset_count <= reset_count + 1;
        end else begin
            reset <= 1'b0;
        end
    end

    task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL t=%0t row %0d %s got %h expected %h",
                     $time, current_row, name, got, expected);
        end
    endtask

    // dec must stay cleared while reset is high and on the edge it drops
    task automatic wait_reset_release(output logic done);
        int cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check_count++;
            if (dec !== '0) begin
                error_count++;
                $display("FAIL t=%0t dec got %h expected all zero", $time, dec);
            end
            compare_value("dec.fields.illegal", 64'(dec.fields.illegal), 64'h0);
            if (reset == 1'b0) begin
                done = 1'b1;
            end
        end
    endtask

    task automatic check_row(input vec_t r);
        logic [XLEN-1:0] exp_rs1;
        logic [XLEN-1:0] exp_rs2;
        // read sees the registers before this row's own write
        exp_rs1 = reg_model[r.rs1];
        exp_rs2 = reg_model[r.rs2];
        compare_value("dec.fields.opcode", 64'(dec.fields.opcode), 64'(r.instr[6:0]));
        compare_value("dec.fields.funct7", 64'(dec.fields.funct7), 64'(r.instr[31:25]));
        compare_value("dec.fields.fmt", 64'(dec.fields.fmt), 64'(r.fmt));
        compare_value("dec.fields.rd", 64'(dec.fields.rd), 64'(r.rd));
        compare_value("dec.fields.rs1", 64'(dec.fields.rs1), 64'(r.rs1));
        compare_value("dec.fields.rs2", 64'(dec.fields.rs2), 64'(r.rs2));
        compare_value("dec.fields.funct3", 64'(dec.fields.funct3), 64'(r.funct3));
        compare_value("dec.fields.illegal", 64'(dec.fields.illegal), 64'(r.illegal));
        compare_value("dec.imm", dec.imm, r.imm);
        compare_value("dec.pc", dec.pc, r.pc);
        compare_value("dec.rs1_data", dec.rs1_data, exp_rs1);
        compare_value("dec.rs2_data", dec.rs2_data, exp_rs2);
        // x0 never takes a write
        if (r.wb_en && r.wb_rd != '0) begin
            reg_model[r.wb_rd] = data_pool[r.slot];
        end
    endtask

    // row i is driven at one edge, sampled at the next, checked at the following negedge
    task automatic run_table();
        vec_t row;
        vec_t prev;
        int   i;
        row  = '0;
        prev = '0;
        for (i = 0; i <= NUM_VECS; i++) begin
            @(posedge clk);
            if (i < NUM_VECS) begin
                row = vector_row(i);
                instr <= row.instr;
                pc    <= row.pc;
                wb    <= '{row.wb_en, row.wb_rd, data_pool[row.slot]};
            end else begin
                instr <= NOP;
                pc    <= '0;
                wb    <= '0;
            end
            if (i > 0) begin
                @(negedge clk);
                current_row = i - 1;
                check_row(prev);
            end
            prev = row;
        end
    endtask

    initial begin
        reset       = 1'b1;
        reset_count = 0;
        instr       = NOP;
        pc          = '0;
        wb          = '0;
        error_count = 0;
        check_count = 0;
        current_row = -1;
        seed_sink   = $urandom(32'h93984247);
        for (int s = 0; s < 8; s++) begin
            data_pool[s] = {$urandom, $urandom};
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            reg_model[r] = '0;
        end
        wait_reset_release(released);
        if (!released) begin
            $display("reset did not drop within %0d cycles", RESET_TIMEOUT);
            $display("Something failed");
            $finish;
        end else begin
            run_table();
            $display("checks: %0d  errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

// File: design/decode_stage.sv
// one instruction per cycle, 1 cycle latency, no stall or flush input; wb is applied on every edge it is valid
`timescale 1ns/1ps

module decode_stage #(
    parameter int DATA_W = decode_pkg::XLEN,
    parameter int ADDR_W = decode_pkg::REG_ADDR_W
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [decode_pkg::INSTR_W-1:0] instr,
    input  logic [decode_pkg::XLEN-1:0]    pc,
    input  decode_pkg::wb_t                wb,
    output decode_pkg::decoded_t           dec
);
    import decode_pkg::*;

    // combinational decode of the current instruction
    fields_t         fields;
    logic [XLEN-1:0] imm;

    // pipeline register, aligned with the register file read data
    fields_t         fields_q;
    logic [XLEN-1:0] imm_q;
    logic [XLEN-1:0] pc_q;

    // registered source operands
    logic [DATA_W-1:0] rs1_data;
    logic [DATA_W-1:0] rs2_data;

    instr_field_decoder u_field_dec (
        .instr  (instr),
        .fields (fields)
    );

    imm_generator u_imm_gen (
        .instr (instr),
        .fmt   (fields.fmt),
        .imm   (imm)
    );

    // indices already zeroed by the decoder where unused
    register_file #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W)
    ) u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (fields.rs1),
        .rd_addr_b (fields.rs2),
        .wb        (wb),
        .rd_data_a (rs1_data),
        .rd_data_b (rs2_data)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            fields_q <= '0;
            imm_q    <= '0;
            pc_q     <= '0;
        end else begin
            fields_q <= fields;
            imm_q    <= imm;
            pc_q     <= pc;
        end
    end

    // join decode and operand data into the execute bundle
    assign dec.fields   = fields_q;
    assign dec.imm      = imm_q;
    assign dec.pc       = pc_q;
    assign dec.rs1_data = rs1_data;
    assign dec.rs2_data = rs2_data;

    // U and J forms read x0 through both ports on the next cycle
    a_uj_no_operands : assert property (
        @(posedge clk) disable iff (reset)
        (fields.fmt == FMT_U || fields.fmt == FMT_J)
            |=> (dec.rs1_data == '0 && dec.rs2_data == '0)
    ) else $error("U/J instruction returned register data");

    // illegal opcode reaches execute with no immediate
    a_illegal_no_imm : assert property (
        @(posedge clk) disable iff (reset)
        dec.fields.illegal |-> (dec.fields.fmt == FMT_R && dec.imm == '0)
    ) else $error("illegal instruction carries fmt %0d imm %h", dec.fields.fmt, dec.imm);

endmodule

// File: design/register_file.sv
// 32 x XLEN integer registers; reads are registered and see the value before a same-edge write
`timescale 1ns/1ps

module register_file #(
    parameter int DATA_W = decode_pkg::XLEN,
    parameter int ADDR_W = decode_pkg::REG_ADDR_W
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] rd_addr_a,
    input  logic [ADDR_W-1:0] rd_addr_b,
    input  decode_pkg::wb_t   wb,
    output logic [DATA_W-1:0] rd_data_a,
    output logic [DATA_W-1:0] rd_data_b
);
    import decode_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    // architectural registers, entry 0 never written
    logic [DATA_W-1:0] regs [DEPTH];

    // write qualified by x0 filter
    logic wr_en;

    // writeback port is fixed to the package widths
    if (DATA_W != XLEN || ADDR_W != REG_ADDR_W || DEPTH != NUM_REGS) begin : g_param_check
        $error("register_file widths do not match the writeback port");
    end

    assign wr_en = wb.en && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
            rd_data_a <= '0;
            rd_data_b <= '0;
        end else begin
            // nonblocking, so a same-edge write is not seen here
            rd_data_a <= regs[rd_addr_a];
            rd_data_b <= regs[rd_addr_b];
            if (wr_en) begin
                regs[wb.rd] <= wb.data;
            end
        end
    end

    // x0 reads back zero on both ports, whatever was written to it
    a_x0_port_a : assert property (
        @(posedge clk) disable iff (reset)
        (rd_addr_a == '0) |=> (rd_data_a == '0)
    ) else $error("x0 read nonzero on port a: %h", rd_data_a);

    a_x0_port_b : assert property (
        @(posedge clk) disable iff (reset)
        (rd_addr_b == '0) |=> (rd_data_b == '0)
    ) else $error("x0 read nonzero on port b: %h", rd_data_b);

endmodule

// File: design/imm_generator.sv
// combinational; trusts fmt from the field decoder, shift amounts come out as plain I immediates
`timescale 1ns/1ps

module imm_generator (
    input  logic [decode_pkg::INSTR_W-1:0] instr,
    input  decode_pkg::fmt_e               fmt,
    output logic [decode_pkg::XLEN-1:0]    imm
);
    import decode_pkg::*;

    // instruction sign bit, shared by every format
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (fmt)
            // 12 bit, loads, alu immediates, jalr, csr address
            FMT_I: begin
                imm = {{(XLEN - 12){sign}}, instr[31:20]};
            end

            // 12 bit split around rd
            FMT_S: begin
                imm = {{(XLEN - 12){sign}}, instr[31:25], instr[11:7]};
            end

            // 13 bit branch offset, halfword aligned
            FMT_B: begin
                imm = {{(XLEN - 12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end

            // upper 20 bits, sign goes on above bit 31
            FMT_U: begin
                imm = {{(XLEN - 32){sign}}, instr[31:12], 12'b0};
            end

            // 21 bit jump offset, halfword aligned
            FMT_J: begin
                imm = {{(XLEN - 20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end

            // register ops and illegal opcodes
            default: begin
                imm = '0;
            end
        endcase
    end

    // control transfer targets must stay halfword aligned
    always_comb begin
        if (fmt == FMT_B || fmt == FMT_J) begin
            assert (imm[0] == 1'b0)
                else $error("odd branch/jump offset %h for fmt %0d", imm, fmt);
        end
    end

endmodule

// File: design/instr_field_decoder.sv
// purely combinational; any major opcode outside the 13 of opcode_e is flagged illegal, funct7 sub-ops are not checked
`timescale 1ns/1ps

module instr_field_decoder (
    input  logic [decode_pkg::INSTR_W-1:0] instr,
    output decode_pkg::fields_t            fields
);
    import decode_pkg::*;

    // major opcode, cast so the case items read as names
    opcode_e op;

    // raw register indices at their fixed positions
    logic [REG_ADDR_W-1:0] raw_rd;
    logic [REG_ADDR_W-1:0] raw_rs1;
    logic [REG_ADDR_W-1:0] raw_rs2;

    assign op      = opcode_e'(instr[6:0]);
    assign raw_rd  = instr[11:7];
    assign raw_rs1 = instr[19:15];
    assign raw_rs2 = instr[24:20];

    always_comb begin
        // fixed positions for every format
        fields.opcode  = instr[6:0];
        fields.funct3  = instr[14:12];
        fields.funct7  = instr[31:25];
        fields.rd      = raw_rd;
        fields.rs1     = raw_rs1;
        fields.rs2     = raw_rs2;
        fields.fmt     = FMT_R;
        fields.illegal = 1'b0;

        case (op)
            // register-register alu, mul/div included
            OP, OP_32: begin
                fields.fmt = FMT_R;
            end

            // loads, alu immediates, jalr, system
            // bits 24..20 belong to the immediate or csr address
            JALR, LOAD, OP_IMM, OP_IMM_32, SYSTEM: begin
                fields.fmt = FMT_I;
                fields.rs2 = '0;
            end

            // fence carries no register operands in use
            MISC_MEM: begin
                fields.fmt = FMT_I;
                fields.rd  = '0;
                fields.rs1 = '0;
                fields.rs2 = '0;
            end

            // stores
            // bits 11..7 are the low immediate, not a destination
            STORE: begin
                fields.fmt = FMT_S;
                fields.rd  = '0;
            end

            // conditional branches, no destination
            BRANCH: begin
                fields.fmt = FMT_B;
                fields.rd  = '0;
            end

            // lui, auipc
            // upper immediate covers both source fields
            LUI, AUIPC: begin
                fields.fmt = FMT_U;
                fields.rs1 = '0;
                fields.rs2 = '0;
            end

            // jal
            JAL: begin
                fields.fmt = FMT_J;
                fields.rs1 = '0;
                fields.rs2 = '0;
            end

            // anything else
            // R keeps the immediate generator at zero
            default: begin
                fields.fmt     = FMT_R;
                fields.illegal = 1'b1;
            end
        endcase
    end

    // the immediate generator relies on this to give a zero immediate
    always_comb begin
        if (fields.illegal) begin
            assert (fields.fmt == FMT_R)
                else $error("illegal opcode %b decoded with fmt %0d", instr[6:0], fields.fmt);
        end
    end

endmodule

// File: design/decode_pkg.sv
// shared types of the decode stage; RV64IM major opcodes only, compressed instructions are not decoded
package decode_pkg;

    // datapath widths
    localparam int XLEN       = 64;
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // the thirteen major opcodes that the stage accepts
    typedef enum logic [OPCODE_W-1:0] {
        OP        = 7'b0110011,
        OP_32     = 7'b0111011,
        JALR      = 7'b1100111,
        LOAD      = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        JAL       = 7'b1101111,
        // fence, fence.i
        MISC_MEM  = 7'b0001111,
        // ecall, ebreak, csr ops
        SYSTEM    = 7'b1110011
    } opcode_e;

    // base instruction formats
    // FMT_R doubles as the format of an illegal opcode
    typedef enum logic [2:0] {
        FMT_R = 3'd0,
        FMT_I = 3'd1,
        FMT_S = 3'd2,
        FMT_B = 3'd3,
        FMT_U = 3'd4,
        FMT_J = 3'd5
    } fmt_e;

    // decoder output
    // opcode kept raw so an illegal value is still visible downstream
    typedef struct packed {
        logic [OPCODE_W-1:0]   opcode;
        logic [FUNCT3_W-1:0]   funct3;
        logic [FUNCT7_W-1:0]   funct7;
        // unused indices are already zeroed here
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        fmt_e                  fmt;
        logic                  illegal;
    } fields_t;

    // registered bundle toward execute
    // every member belongs to the same instruction
    typedef struct packed {
        fields_t         fields;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
    } decoded_t;

    // writeback port into the register file
    // rd of zero is dropped by the register file
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage
